/* source/dccm_pkg.sv */
// Banked data memory package with default geometry and the bank index type
package dccm_pkg;

   // Stored word width, data plus room for check bits
   localparam int DCCM_DATA_WIDTH = 39;

   // Number of single-port banks, power of two
   localparam int DCCM_NUM_BANKS = 4;

   // Byte address width of the whole memory
   localparam int DCCM_ADDR_BITS = 10;

   // Byte offset inside a 4-byte word, fixed
   localparam int DCCM_OFFSET_BITS = 2;

   // Default derived geometry
   localparam int DCCM_BANK_BITS = $clog2(DCCM_NUM_BANKS);
   localparam int DCCM_INDEX_BITS = DCCM_ADDR_BITS - DCCM_OFFSET_BITS - DCCM_BANK_BITS;

   // 64 words per bank with the defaults
   localparam int DCCM_BANK_DEPTH = 1 << DCCM_INDEX_BITS;

   // Word index inside one bank
   typedef logic [DCCM_INDEX_BITS-1:0] dccm_index_t;

endpackage

/* source/dccm_bank_ram.sv */
// Single-port synchronous bank RAM with enable, write enable and registered output
`timescale 1ns/10ps

module dccm_bank_ram
   import dccm_pkg::*;
#(
   parameter int DATA_WIDTH = DCCM_DATA_WIDTH,
   parameter int NUM_BANKS = DCCM_NUM_BANKS,
   parameter int ADDR_BITS = DCCM_ADDR_BITS,
   localparam int BANK_BITS = $clog2(NUM_BANKS),
   localparam int INDEX_BITS = ADDR_BITS - DCCM_OFFSET_BITS - BANK_BITS
) (
   input  logic                  clk,
   input  logic                  en,
   input  logic                  we,
   input  logic [INDEX_BITS-1:0] index,
   input  logic [DATA_WIDTH-1:0] wdata,
   output logic [DATA_WIDTH-1:0] rdata
);

   localparam int DEPTH = 1 << INDEX_BITS;

   logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

   // One access per cycle, write has priority over read
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[index] <= wdata;
         end else begin
            rdata <= mem[index];
         end
      end
   end

   // rdata keeps the last read word while the bank is idle or written

endmodule

/* source/dccm_bank_steer.sv */
// Bank steering for lo/hi accesses: bank enables, per-bank index and write data
`timescale 1ns/10ps

module dccm_bank_steer
   import dccm_pkg::*;
#(
   parameter int DATA_WIDTH = DCCM_DATA_WIDTH,
   parameter int NUM_BANKS = DCCM_NUM_BANKS,
   parameter int ADDR_BITS = DCCM_ADDR_BITS,
   localparam int BANK_BITS = $clog2(NUM_BANKS),
   localparam int INDEX_BITS = ADDR_BITS - DCCM_OFFSET_BITS - BANK_BITS
) (
   input  logic                                  wren,
   input  logic                                  rden,
   input  logic [ADDR_BITS-1:0]                  wr_addr_lo,
   input  logic [ADDR_BITS-1:0]                  wr_addr_hi,
   input  logic [ADDR_BITS-1:0]                  rd_addr_lo,
   input  logic [ADDR_BITS-1:0]                  rd_addr_hi,
   input  logic [DATA_WIDTH-1:0]                 wr_data_lo,
   input  logic [DATA_WIDTH-1:0]                 wr_data_hi,
   output logic [NUM_BANKS-1:0]                  bank_en,
   output logic [NUM_BANKS-1:0]                  bank_we,
   output logic [NUM_BANKS-1:0][INDEX_BITS-1:0]  bank_index,
   output logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]  bank_wdata
);

   // Bit position of the index field
   localparam int INDEX_LSB = DCCM_OFFSET_BITS + BANK_BITS;

   logic [BANK_BITS-1:0]  wr_bank_lo;
   logic [BANK_BITS-1:0]  wr_bank_hi;
   logic [BANK_BITS-1:0]  rd_bank_lo;
   logic [BANK_BITS-1:0]  rd_bank_hi;
   logic [INDEX_BITS-1:0] wr_index_lo;
   logic [INDEX_BITS-1:0] wr_index_hi;
   logic [INDEX_BITS-1:0] rd_index_lo;
   logic [INDEX_BITS-1:0] rd_index_hi;
   logic                  wr_unaligned;
   logic                  rd_unaligned;

   logic [NUM_BANKS-1:0]  wr_hit;
   logic [NUM_BANKS-1:0]  rd_hit;
   logic [NUM_BANKS-1:0]  wr_take_hi;
   logic [NUM_BANKS-1:0]  rd_take_hi;

   // Bank field sits right above the byte offset, index above that
   assign wr_bank_lo = wr_addr_lo[DCCM_OFFSET_BITS +: BANK_BITS];
   assign wr_bank_hi = wr_addr_hi[DCCM_OFFSET_BITS +: BANK_BITS];
   assign rd_bank_lo = rd_addr_lo[DCCM_OFFSET_BITS +: BANK_BITS];
   assign rd_bank_hi = rd_addr_hi[DCCM_OFFSET_BITS +: BANK_BITS];

   assign wr_index_lo = wr_addr_lo[INDEX_LSB +: INDEX_BITS];
   assign wr_index_hi = wr_addr_hi[INDEX_LSB +: INDEX_BITS];
   assign rd_index_lo = rd_addr_lo[INDEX_LSB +: INDEX_BITS];
   assign rd_index_hi = rd_addr_hi[INDEX_LSB +: INDEX_BITS];

   // Lo and hi halves in different banks means a misaligned word
   assign wr_unaligned = (wr_bank_lo != wr_bank_hi);
   assign rd_unaligned = (rd_bank_lo != rd_bank_hi);

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank

      // Bank touched by either half of the access
      assign wr_hit[i] = wren & ((wr_bank_lo == BANK_BITS'(i)) |
                                 (wr_bank_hi == BANK_BITS'(i)));
      assign rd_hit[i] = rden & ((rd_bank_lo == BANK_BITS'(i)) |
                                 (rd_bank_hi == BANK_BITS'(i)));

      // Hi half only when it really lands in another bank
      assign wr_take_hi[i] = wr_unaligned & (wr_bank_hi == BANK_BITS'(i));
      assign rd_take_hi[i] = rd_unaligned & (rd_bank_hi == BANK_BITS'(i));

      assign bank_en[i] = wr_hit[i] | rd_hit[i];
      assign bank_we[i] = wr_hit[i];

      // Write owns the bank when both want it
      always_comb begin
         if (wr_hit[i]) begin
            bank_index[i] = wr_take_hi[i] ? wr_index_hi : wr_index_lo;
         end else begin
            bank_index[i] = rd_take_hi[i] ? rd_index_hi : rd_index_lo;
         end
      end

      assign bank_wdata[i] = wr_take_hi[i] ? wr_data_hi : wr_data_lo;

   end : g_bank

endmodule

/* source/dccm_rd_align.sv */
// Read data alignment, picks lo and hi words from the bank outputs one cycle later
`timescale 1ns/10ps

module dccm_rd_align
   import dccm_pkg::*;
#(
   parameter int DATA_WIDTH = DCCM_DATA_WIDTH,
   parameter int NUM_BANKS = DCCM_NUM_BANKS,
   parameter int ADDR_BITS = DCCM_ADDR_BITS,
   localparam int BANK_BITS = $clog2(NUM_BANKS)
) (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [ADDR_BITS-1:0]                 rd_addr_lo,
   input  logic [ADDR_BITS-1:0]                 rd_addr_hi,
   input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata,
   output logic [DATA_WIDTH-1:0]                rd_data_lo,
   output logic [DATA_WIDTH-1:0]                rd_data_hi
);

   logic [BANK_BITS-1:0] rd_bank_lo_q;
   logic [BANK_BITS-1:0] rd_bank_hi_q;

   // Track which banks the RAM outputs belong to
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_bank_lo_q <= '0;
         rd_bank_hi_q <= '0;
      end else begin
         rd_bank_lo_q <= rd_addr_lo[DCCM_OFFSET_BITS +: BANK_BITS];
         rd_bank_hi_q <= rd_addr_hi[DCCM_OFFSET_BITS +: BANK_BITS];
      end
   end

   // Aligned access gives the same word on both outputs
   assign rd_data_lo = bank_rdata[rd_bank_lo_q];
   assign rd_data_hi = bank_rdata[rd_bank_hi_q];

endmodule

/* source/dccm_mem.sv */
// Banked single-port data memory for the load/store pipe with misaligned access support
`timescale 1ns/10ps

module dccm_mem
   import dccm_pkg::*;
#(
   parameter int DATA_WIDTH = DCCM_DATA_WIDTH,
   parameter int NUM_BANKS = DCCM_NUM_BANKS,
   parameter int ADDR_BITS = DCCM_ADDR_BITS
) (
   input  logic                  clk,
   input  logic                  arst_n,

   // Request from the core
   input  logic                  wren,
   input  logic                  rden,
   input  logic [ADDR_BITS-1:0]  wr_addr_lo,
   input  logic [ADDR_BITS-1:0]  wr_addr_hi,
   input  logic [ADDR_BITS-1:0]  rd_addr_lo,
   input  logic [ADDR_BITS-1:0]  rd_addr_hi,
   input  logic [DATA_WIDTH-1:0] wr_data_lo,
   input  logic [DATA_WIDTH-1:0] wr_data_hi,

   // Read data, one cycle after rden
   output logic [DATA_WIDTH-1:0] rd_data_lo,
   output logic [DATA_WIDTH-1:0] rd_data_hi
);

   localparam int BANK_BITS = $clog2(NUM_BANKS);
   localparam int INDEX_BITS = ADDR_BITS - DCCM_OFFSET_BITS - BANK_BITS;

   logic [NUM_BANKS-1:0]                 bank_en;
   logic [NUM_BANKS-1:0]                 bank_we;
   logic [NUM_BANKS-1:0][INDEX_BITS-1:0] bank_index;
   logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_wdata;
   logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata;

   dccm_bank_steer #(
      .DATA_WIDTH (DATA_WIDTH),
      .NUM_BANKS  (NUM_BANKS),
      .ADDR_BITS  (ADDR_BITS)
   ) u_steer (
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .bank_en    (bank_en),
      .bank_we    (bank_we),
      .bank_index (bank_index),
      .bank_wdata (bank_wdata)
   );

   // One RAM per bank, enabled only when accessed
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      dccm_bank_ram #(
         .DATA_WIDTH (DATA_WIDTH),
         .NUM_BANKS  (NUM_BANKS),
         .ADDR_BITS  (ADDR_BITS)
      ) u_ram (
         .clk   (clk),
         .en    (bank_en[i]),
         .we    (bank_we[i]),
         .index (bank_index[i]),
         .wdata (bank_wdata[i]),
         .rdata (bank_rdata[i])
      );
   end : g_bank

   dccm_rd_align #(
      .DATA_WIDTH (DATA_WIDTH),
      .NUM_BANKS  (NUM_BANKS),
      .ADDR_BITS  (ADDR_BITS)
   ) u_rd_align (
      .clk        (clk),
      .arst_n     (arst_n),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .bank_rdata (bank_rdata),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

endmodule

/* tests/tb_dccm_mem.sv */
// Testbench for the banked data memory with a shadow model checked by assertions on read data
`timescale 1ns/10ps

module tb_dccm_mem
   import dccm_pkg::*;
;

   localparam int CLK_PERIOD = 20;
   localparam int WORD_BITS = DCCM_ADDR_BITS - DCCM_OFFSET_BITS;
   localparam int NUM_WORDS = 1 << WORD_BITS;
   localparam int RANDOM_OPS = 200;

   // Cycles for reset, memory fill, directed tests with flush cycles and the random test
   localparam int TEST_CYCLES = 3 + NUM_WORDS + 4 * 6 + RANDOM_OPS + 2 + 8;
   localparam int TIMEOUT_NS = TEST_CYCLES * CLK_PERIOD + 2000;

   logic                       clk;
   logic                       arst_n;
   logic                       wren;
   logic                       rden;
   logic [DCCM_ADDR_BITS-1:0]  wr_addr_lo;
   logic [DCCM_ADDR_BITS-1:0]  wr_addr_hi;
   logic [DCCM_ADDR_BITS-1:0]  rd_addr_lo;
   logic [DCCM_ADDR_BITS-1:0]  rd_addr_hi;
   logic [DCCM_DATA_WIDTH-1:0] wr_data_lo;
   logic [DCCM_DATA_WIDTH-1:0] wr_data_hi;
   logic [DCCM_DATA_WIDTH-1:0] rd_data_lo;
   logic [DCCM_DATA_WIDTH-1:0] rd_data_hi;

   // Shadow of the memory indexed by word address
   logic [DCCM_DATA_WIDTH-1:0] shadow [0:NUM_WORDS-1];

   // Read issued last cycle and the check armed for this cycle
   logic                       pend_valid;
   logic [DCCM_DATA_WIDTH-1:0] pend_lo;
   logic [DCCM_DATA_WIDTH-1:0] pend_hi;
   logic                       chk_valid;
   logic [DCCM_DATA_WIDTH-1:0] exp_lo;
   logic [DCCM_DATA_WIDTH-1:0] exp_hi;

   integer seed;
   int     err_count;
   int     check_count;
   int     tests_passed;
   int     tests_failed;
   int     test_err_start;
   int     test_chk_start;

   dccm_mem #(
      .DATA_WIDTH (DCCM_DATA_WIDTH),
      .NUM_BANKS  (DCCM_NUM_BANKS),
      .ADDR_BITS  (DCCM_ADDR_BITS)
   ) dut0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Read data must match the shadow one cycle after the request
   rd_lo_check: assert property (@(posedge clk) disable iff (!arst_n)
      chk_valid |-> (rd_data_lo == exp_lo))
   else begin
      err_count = err_count + 1;
      $display("error at %0d ns: rd_data_lo expected %h actual %h",
               $time, $sampled(exp_lo), $sampled(rd_data_lo));
   end

   rd_hi_check: assert property (@(posedge clk) disable iff (!arst_n)
      chk_valid |-> (rd_data_hi == exp_hi))
   else begin
      err_count = err_count + 1;
      $display("error at %0d ns: rd_data_hi expected %h actual %h",
               $time, $sampled(exp_hi), $sampled(rd_data_hi));
   end

   // Word address of the hi half with wrap into bank 0 at the next index
   function automatic logic [WORD_BITS-1:0] hi_word(input logic [WORD_BITS-1:0] w,
                                                    input logic unal);
      return unal ? (w + WORD_BITS'(1)) : w;
   endfunction

   function automatic logic [DCCM_BANK_BITS-1:0] bank_of(input logic [WORD_BITS-1:0] w);
      return w[DCCM_BANK_BITS-1:0];
   endfunction

   function automatic logic banks_overlap(input logic [WORD_BITS-1:0] wa, input logic wu,
                                          input logic [WORD_BITS-1:0] ra, input logic ru);
      logic [DCCM_BANK_BITS-1:0] wl;
      logic [DCCM_BANK_BITS-1:0] wh;
      logic [DCCM_BANK_BITS-1:0] rl;
      logic [DCCM_BANK_BITS-1:0] rh;
      wl = bank_of(wa);
      wh = bank_of(hi_word(wa, wu));
      rl = bank_of(ra);
      rh = bank_of(hi_word(ra, ru));
      return (wl == rl) || (wl == rh) || (wh == rl) || (wh == rh);
   endfunction

   // Fill pattern built from every bit of the word address
   function automatic logic [DCCM_DATA_WIDTH-1:0] fill_word(input logic [WORD_BITS-1:0] w);
      return DCCM_DATA_WIDTH'({w, 8'h5a, ~w, w ^ 8'h3c, w[6:0]});
   endfunction

   function automatic logic [DCCM_DATA_WIDTH-1:0] rand_word();
      return DCCM_DATA_WIDTH'({$random(seed), $random(seed)});
   endfunction

   // Arms the check for last cycle's read and drives the new request
   task automatic step(input logic wr, input logic wu, input logic [WORD_BITS-1:0] ww,
                       input logic [DCCM_DATA_WIDTH-1:0] dlo,
                       input logic [DCCM_DATA_WIDTH-1:0] dhi,
                       input logic rd, input logic ru, input logic [WORD_BITS-1:0] rw);
      logic [WORD_BITS-1:0] ww_hi;
      logic [WORD_BITS-1:0] rw_hi;
      @(negedge clk);
      ww_hi = hi_word(ww, wu);
      rw_hi = hi_word(rw, ru);
      chk_valid = pend_valid;
      exp_lo = pend_lo;
      exp_hi = pend_hi;
      if (pend_valid) begin
         check_count = check_count + 1;
      end
      wren = wr;
      rden = rd;
      // Unaligned lo starts mid word and hi starts its own word
      wr_addr_lo = {ww, wu ? 2'b10 : 2'b00};
      wr_addr_hi = {ww_hi, wu ? 2'b00 : 2'b11};
      rd_addr_lo = {rw, ru ? 2'b10 : 2'b00};
      rd_addr_hi = {rw_hi, ru ? 2'b00 : 2'b11};
      wr_data_lo = dlo;
      wr_data_hi = dhi;
      pend_valid = rd;
      if (rd) begin
         pend_lo = shadow[rw];
         pend_hi = shadow[rw_hi];
      end
      if (wr) begin
         shadow[ww] = dlo;
         if (wu) begin
            shadow[ww_hi] = dhi;
         end
      end
   endtask

   task automatic idle();
      step(1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic begin_test();
      test_err_start = err_count;
      test_chk_start = check_count;
   endtask

   // Two idle cycles let the last read reach its assertion
   task automatic finish_test(input string name);
      int errs;
      int checks;
      idle();
      idle();
      errs = err_count - test_err_start;
      checks = check_count - test_chk_start;
      if (errs == 0 && checks > 0) begin
         tests_passed = tests_passed + 1;
         $display("test %s: %0d reads checked, passed", name, checks);
      end else begin
         tests_failed = tests_failed + 1;
         if (checks == 0) begin
            $display("test %s: no read was checked, failed", name);
         end else begin
            $display("test %s: %0d reads checked, %0d mismatches, failed", name, checks, errs);
         end
      end
   endtask

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      logic [DCCM_DATA_WIDTH-1:0] d0;
      logic [DCCM_DATA_WIDTH-1:0] d1;
      logic [31:0]                r;
      logic                       wr;
      logic                       rd;
      logic                       wu;
      logic                       ru;
      logic [WORD_BITS-1:0]       ww;
      logic [WORD_BITS-1:0]       rw;

      seed = 32'hd327_af1b;
      clk = 1'b0;
      arst_n = 1'b0;
      wren = 1'b0;
      rden = 1'b0;
      wr_addr_lo = '0;
      wr_addr_hi = '0;
      rd_addr_lo = '0;
      rd_addr_hi = '0;
      wr_data_lo = '0;
      wr_data_hi = '0;
      pend_valid = 1'b0;
      pend_lo = '0;
      pend_hi = '0;
      chk_valid = 1'b0;
      exp_lo = '0;
      exp_hi = '0;
      err_count = 0;
      check_count = 0;
      tests_passed = 0;
      tests_failed = 0;
      test_err_start = 0;
      test_chk_start = 0;

      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Known contents everywhere since the RAMs come up uninitialized
      for (int i = 0; i < NUM_WORDS; i++) begin
         step(1'b1, 1'b0, WORD_BITS'(i), fill_word(WORD_BITS'(i)), '0, 1'b0, 1'b0, '0);
      end

      begin_test();
      d0 = rand_word();
      d1 = rand_word();
      step(1'b1, 1'b0, 8'h05, d0, d1, 1'b0, 1'b0, '0);
      step(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0, 8'h05);
      finish_test("aligned write and read");

      // Hi word is also read alone at its own word address
      begin_test();
      d0 = rand_word();
      d1 = rand_word();
      step(1'b1, 1'b1, 8'h11, d0, d1, 1'b0, 1'b0, '0);
      step(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b1, 8'h11);
      step(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0, 8'h12);
      finish_test("unaligned bank 1 to bank 2");

      begin_test();
      d0 = rand_word();
      d1 = rand_word();
      step(1'b1, 1'b1, 8'h17, d0, d1, 1'b0, 1'b0, '0);
      step(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b1, 8'h17);
      step(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0, 8'h18);
      finish_test("wrap from last bank to bank 0");

      // Read banks 3 and 0 while writing banks 1 and 2
      begin_test();
      d0 = rand_word();
      d1 = rand_word();
      step(1'b1, 1'b1, 8'h21, d0, d1, 1'b1, 1'b1, 8'h23);
      step(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b1, 8'h21);
      finish_test("read and write in disjoint banks");

      begin_test();
      for (int n = 0; n < RANDOM_OPS; n++) begin
         r = $random(seed);
         wr = r[0] | r[4];
         rd = r[1] | r[5];
         wu = r[2];
         ru = r[3];
         ww = r[15:8];
         rw = r[23:16];
         // A bank cannot serve a read and a write in one cycle
         if (wr && rd && banks_overlap(ww, wu, rw, ru)) begin
            wr = 1'b0;
         end
         d0 = rand_word();
         d1 = rand_word();
         step(wr, wu, ww, d0, d1, rd, ru, rw);
      end
      finish_test("random reads and writes");

      $display("tests passed %0d, tests failed %0d, read mismatches %0d",
               tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* compile.f */
source/dccm_pkg.sv
source/dccm_bank_ram.sv
source/dccm_bank_steer.sv
source/dccm_rd_align.sv
source/dccm_mem.sv
tests/tb_dccm_mem.sv

/* run.sh */
#!/bin/sh
# Compile the memory and its testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
   -f compile.f \
   --top-module tb_dccm_mem \
   -Mdir obj_dir > build.log 2>&1 \
   && ./obj_dir/Vtb_dccm_mem > sim.log 2>&1 \
   || { cat build.log; [ -f sim.log ] && cat sim.log; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; }

grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a result"; exit 1; }

exit 0
